// File: trellisPkg.sv
/*
 * Shared types for the SOQPSK trellis front end. Samples are 18-bit signed I/Q.
 * Register offsets decode from the low address bits inside one 32-word space.
 */
package trellisPkg;

    // ----------------------------------------------------------
    // widths
    // ----------------------------------------------------------
    localparam int sampleWidth = 18;
    localparam int addrWidth = 13;
    localparam int dataWidth = 32;

    // number of DAC monitor channels
    localparam int dacChannels = 3;

    // ----------------------------------------------------------
    // register space layout
    // ----------------------------------------------------------
    // upper address bits from here up are compared with the space base
    localparam int spaceDecodeLsb = 5;

    // low address bits that select a register
    localparam int regAddrWidth = 2;

    // control register bits
    localparam int ctrlSlipBit = 0;
    localparam int ctrlDelayBit = 1;

    // width of one DAC select field, channel n sits at bits [2n+1:2n]
    localparam int dacSelWidth = 2;

    // ----------------------------------------------------------
    // datapath types
    // ----------------------------------------------------------
    typedef struct packed {
        logic signed [sampleWidth-1:0] i;
        logic signed [sampleWidth-1:0] q;
    } sample_t;

    // symbol timing strobes, each a single-cycle enable
    typedef struct packed {
        logic symEnEven;
        logic symEn;
        logic sym2xEn;
    } strobes_t;

    // ----------------------------------------------------------
    // register and control types
    // ----------------------------------------------------------
    typedef enum logic [regAddrWidth-1:0] {
        regControl   = 2'd0,
        regDacSelect = 2'd1
    } regAddr_t;

    // monitor source per DAC channel; code 3 behaves as off
    typedef enum logic [dacSelWidth-1:0] {
        dacOff      = 2'd0,
        dacTrellisI = 2'd1,
        dacTrellisQ = 2'd2
    } dacSource_t;

    // field order gives symbolSlip at bit 0 and symbolDelay at bit 1
    typedef struct packed {
        logic symbolDelay;
        logic symbolSlip;
    } control_t;

    typedef dacSource_t [dacChannels-1:0] dacSelect_t;

endpackage

// File: trellisRegDecode.sv
/*
 * Register space of the trellis front end, written on clk when cs and wr0 are high.
 * The slip request bit self-clears when the slipper reports the slip as taken.
 */
`timescale 1ns/1ps

module trellisRegDecode
    import trellisPkg::*;
#(
    parameter logic [addrWidth-1:0] multihSpaceBase = 13'h0A00
) (
    input  logic                 clk,
    input  logic                 symbolSlipped,
    input  logic                 cs,
    input  logic                 wr0,
    input  logic [addrWidth-1:0] addr,
    input  logic [dataWidth-1:0] din,
    input  logic                 slipTaken,
    output logic [dataWidth-1:0] dout,
    output control_t             control,
    output dacSelect_t           dacSelect
);

    logic     inSpace;
    logic     wrEn;
    regAddr_t regSel;

    // ----------------------------------------------------------
    // address decode
    // ----------------------------------------------------------
    assign inSpace = cs && (addr[addrWidth-1:spaceDecodeLsb]
                            == multihSpaceBase[addrWidth-1:spaceDecodeLsb]);
    assign regSel  = regAddr_t'(addr[regAddrWidth-1:0]);
    assign wrEn    = inSpace && wr0;

    // ----------------------------------------------------------
    // control register
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge symbolSlipped) begin
        if (symbolSlipped) begin
            control <= '0;
        end else begin
            if (wrEn && regSel == regControl) begin
                control.symbolDelay <= din[ctrlDelayBit];
            end
            // taken slip wins over a write in the same cycle
            if (slipTaken) begin
                control.symbolSlip <= 1'b0;
            end else if (wrEn && regSel == regControl) begin
                control.symbolSlip <= din[ctrlSlipBit];
            end
        end
    end

    // ----------------------------------------------------------
    // DAC select register
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge symbolSlipped) begin
        if (symbolSlipped) begin
            for (int n = 0; n < dacChannels; n++) begin
                dacSelect[n] <= dacOff;
            end
        end else if (wrEn && regSel == regDacSelect) begin
            for (int n = 0; n < dacChannels; n++) begin
                dacSelect[n] <= dacSource_t'(din[n*dacSelWidth +: dacSelWidth]);
            end
        end
    end

    // readback, zero outside the space and for unused offsets
    always_comb begin
        dout = '0;
        if (inSpace) begin
            case (regSel)
                regControl: begin
                    dout[ctrlSlipBit]  = control.symbolSlip;
                    dout[ctrlDelayBit] = control.symbolDelay;
                end
                regDacSelect: begin
                    dout[dacChannels*dacSelWidth-1:0] = dacSelect;
                end
                default: begin
                    dout = '0;
                end
            endcase
        end
    end

endmodule

// File: symbolSlipper.sv
/*
 * Reclocks the I/Q samples and symbol strobes by one cycle.
 * A pending slip request drops exactly one symEn; the other strobes pass as they are.
 */
`timescale 1ns/1ps

module symbolSlipper
    import trellisPkg::*;
(
    input  logic     clk,
    input  logic     symbolSlipped,
    input  sample_t  sampleIn,
    input  strobes_t strobesIn,
    input  logic     slipRequest,
    output sample_t  sample,
    output strobes_t strobes,
    output logic     slipTaken
);

    // request still open and not already served this cycle
    logic slipArmed;
    logic dropSymEn;

    // the request bit clears one cycle after slipTaken, so mask it meanwhile
    assign slipArmed = slipRequest && !slipTaken;
    assign dropSymEn = slipArmed && strobesIn.symEn;

    // ----------------------------------------------------------
    // sample reclock
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        sample <= sampleIn;
    end

    // ----------------------------------------------------------
    // strobe reclock and slip
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge symbolSlipped) begin
        if (symbolSlipped) begin
            strobes   <= '0;
            slipTaken <= 1'b0;
        end else begin
            strobes.symEnEven <= strobesIn.symEnEven;
            strobes.sym2xEn   <= strobesIn.sym2xEn;
            if (dropSymEn) begin
                // swallow this symbol, timing moves one symbol later
                strobes.symEn <= 1'b0;
                slipTaken     <= 1'b1;
            end else begin
                strobes.symEn <= strobesIn.symEn;
                slipTaken     <= 1'b0;
            end
        end
    end

endmodule

// File: sampleAligner.sv
/*
 * Latches I/Q on each sym2xEn strobe, optionally one strobe late.
 * Strobes leave one cycle delayed so they line up with the latched sample.
 */
`timescale 1ns/1ps

module sampleAligner
    import trellisPkg::*;
(
    input  logic     clk,
    input  logic     symbolSlipped,
    input  sample_t  sample,
    input  strobes_t strobes,
    input  logic     symbolDelay,
    output sample_t  sampleOut,
    output strobes_t strobesOut
);

    // sample taken at the previous sym2xEn strobe
    sample_t heldSample;

    // ----------------------------------------------------------
    // half-rate latch
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge symbolSlipped) begin
        if (symbolSlipped) begin
            heldSample <= '0;
            sampleOut  <= '0;
        end else if (strobes.sym2xEn) begin
            heldSample <= sample;
            // half-symbol delay picks the older sample
            if (symbolDelay) begin
                sampleOut <= heldSample;
            end else begin
                sampleOut <= sample;
            end
        end
    end

    // strobes follow the latch by one cycle
    always_ff @(posedge clk or posedge symbolSlipped) begin
        if (symbolSlipped) begin
            strobesOut <= '0;
        end else begin
            strobesOut <= strobes;
        end
    end

endmodule

// File: dacOutputMux.sv
/*
 * Three registered DAC monitor channels, one cycle behind the aligned sample.
 * Select codes other than I or Q give zero data with the clock enable held low.
 */
`timescale 1ns/1ps

module dacOutputMux
    import trellisPkg::*;
(
    input  logic                          clk,
    input  logic                          symbolSlipped,
    input  sample_t                       sample,
    input  logic                          sampleEn,
    input  dacSelect_t                    dacSelect,
    output logic signed [sampleWidth-1:0] dacData [dacChannels],
    output logic [dacChannels-1:0]        dacClkEn
);

    // ----------------------------------------------------------
    // per-channel source select
    // ----------------------------------------------------------
    for (genvar ch = 0; ch < dacChannels; ch++) begin : gChannel
        logic signed [sampleWidth-1:0] chData;
        logic                          chClkEn;

        always_ff @(posedge clk or posedge symbolSlipped) begin
            if (symbolSlipped) begin
                chData  <= '0;
                chClkEn <= 1'b0;
            end else begin
                case (dacSelect[ch])
                    dacTrellisI: begin
                        chData  <= sample.i;
                        chClkEn <= sampleEn;
                    end
                    dacTrellisQ: begin
                        chData  <= sample.q;
                        chClkEn <= sampleEn;
                    end
                    dacOff: begin
                        chData  <= '0;
                        chClkEn <= 1'b0;
                    end
                    default: begin
                        // unused code, treat as off
                        chData  <= '0;
                        chClkEn <= 1'b0;
                    end
                endcase
            end
        end

        assign dacData[ch]  = chData;
        assign dacClkEn[ch] = chClkEn;
    end

endmodule

// File: trellisFrontEnd.sv
/*
 * Front end of the multi-h SOQPSK trellis demodulator, all on one clock.
 * Samples and strobes reach the outputs 2 cycles after input, DACs after 3.
 */
`timescale 1ns/1ps

module trellisFrontEnd
    import trellisPkg::*;
#(
    parameter logic [addrWidth-1:0] multihSpaceBase = 13'h0A00
) (
    input  logic                          clk,
    input  logic                          symbolSlipped,
    input  sample_t                       sampleIn,
    input  strobes_t                      strobesIn,
    input  logic                          cs,
    input  logic                          wr0,
    input  logic [addrWidth-1:0]          addr,
    input  logic [dataWidth-1:0]          din,
    output logic [dataWidth-1:0]          dout,
    output logic signed [sampleWidth-1:0] dacData [dacChannels],
    output logic [dacChannels-1:0]        dacClkEn,
    output sample_t                       sampleOut,
    output strobes_t                      strobesOut
);

    control_t   control;
    dacSelect_t dacSelect;
    sample_t    slipSample;
    strobes_t   slipStrobes;
    logic       slipTaken;

    // ----------------------------------------------------------
    // decode
    // ----------------------------------------------------------
    trellisRegDecode #(
        .multihSpaceBase(multihSpaceBase)
    ) trellisRegDecode_inst (
        .clk          (clk),
        .symbolSlipped(symbolSlipped),
        .cs           (cs),
        .wr0          (wr0),
        .addr         (addr),
        .din          (din),
        .slipTaken    (slipTaken),
        .dout         (dout),
        .control      (control),
        .dacSelect    (dacSelect)
    );

    // ----------------------------------------------------------
    // execute
    // ----------------------------------------------------------
    symbolSlipper symbolSlipper_inst (
        .clk          (clk),
        .symbolSlipped(symbolSlipped),
        .sampleIn     (sampleIn),
        .strobesIn    (strobesIn),
        .slipRequest  (control.symbolSlip),
        .sample       (slipSample),
        .strobes      (slipStrobes),
        .slipTaken    (slipTaken)
    );

    sampleAligner sampleAligner_inst (
        .clk          (clk),
        .symbolSlipped(symbolSlipped),
        .sample       (slipSample),
        .strobes      (slipStrobes),
        .symbolDelay  (control.symbolDelay),
        .sampleOut    (sampleOut),
        .strobesOut   (strobesOut)
    );

    // result, DAC monitors clocked at the half-symbol rate
    dacOutputMux dacOutputMux_inst (
        .clk          (clk),
        .symbolSlipped(symbolSlipped),
        .sample       (sampleOut),
        .sampleEn     (strobesOut.sym2xEn),
        .dacSelect    (dacSelect),
        .dacData      (dacData),
        .dacClkEn     (dacClkEn)
    );

endmodule

// File: tbTrellisChecks.svh
/*
 * Compare tasks, error counters and the xorshift source for the front end testbench.
 * Included inside the testbench module, after the trellisPkg import.
 */
`ifndef TB_TRELLIS_CHECKS_SVH
`define TB_TRELLIS_CHECKS_SVH

// error counts, one per kind of result
int sampleErrors = 0;
int strobeErrors = 0;
int wordErrors = 0;
int dacErrors = 0;
int otherErrors = 0;

// 32-bit xorshift, stays nonzero for a nonzero seed
function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

task automatic compareSample(input string name, input sample_t got, input sample_t want);
    if (got !== want) begin
        sampleErrors++;
        $display("mismatch at %0t: %s got i=%0d q=%0d, expected i=%0d q=%0d",
                 $time, name, got.i, got.q, want.i, want.q);
    end
endtask

task automatic compareStrobes(input string name, input strobes_t got, input strobes_t want);
    if (got !== want) begin
        strobeErrors++;
        $display("mismatch at %0t: %s got %b, expected %b", $time, name, got, want);
    end
endtask

task automatic compareWord(input string name, input logic [dataWidth-1:0] got,
                           input logic [dataWidth-1:0] want);
    if (got !== want) begin
        wordErrors++;
        $display("mismatch at %0t: %s got %h, expected %h", $time, name, got, want);
    end
endtask

task automatic compareDac(input int ch, input logic signed [sampleWidth-1:0] gotData,
                          input logic gotEn, input logic signed [sampleWidth-1:0] wantData,
                          input logic wantEn);
    if (gotData !== wantData || gotEn !== wantEn) begin
        dacErrors++;
        $display("mismatch at %0t: dacData[%0d]/dacClkEn[%0d] got %0d/%b, expected %0d/%b",
                 $time, ch, ch, gotData, gotEn, wantData, wantEn);
    end
endtask

`endif

// File: tbTrellisFrontEnd.sv
/*
 * Self-checking testbench for the trellis front end, run from a step table.
 * Inputs change on the falling edge; a cycle model queues the expected outputs.
 */
`timescale 1ns/1ps

module tbTrellisFrontEnd
    import trellisPkg::*;
();

    `include "tbTrellisChecks.svh"

    localparam logic [addrWidth-1:0] spaceBase = 13'h0A00;
    localparam logic [addrWidth-1:0] ctrlAddr = {spaceBase[addrWidth-1:regAddrWidth], regControl};
    localparam logic [addrWidth-1:0] dacAddr = {spaceBase[addrWidth-1:regAddrWidth], regDacSelect};
    localparam logic [addrWidth-1:0] outsideAddr = 13'h0B00;

    typedef enum {stepRead, stepWrite, stepRun, stepIdle} stepKind_t;

    // for reads, data holds the expected readback
    typedef struct {
        stepKind_t            kind;
        logic [addrWidth-1:0] addr;
        logic [dataWidth-1:0] data;
        int                   cycles;
    } step_t;

    logic                          clk;
    logic                          symbolSlipped;
    sample_t                       sampleIn;
    strobes_t                      strobesIn;
    logic                          cs;
    logic                          wr0;
    logic [addrWidth-1:0]          addr;
    logic [dataWidth-1:0]          din;
    logic [dataWidth-1:0]          dout;
    logic signed [sampleWidth-1:0] dacData [dacChannels];
    logic [dacChannels-1:0]        dacClkEn;
    sample_t                       sampleOut;
    strobes_t                      strobesOut;

    step_t       stepTable[$];
    logic [31:0] rngState = 32'd37;
    int          runCycle = 0;
    int          cycleCount = 0;
    int          timeoutLimit = 0;
    int          symEnIn = 0;
    int          symEnOut = 0;
    int          slipsAsked = 0;

    // model state and expected-value queues
    logic       modelDelay;
    logic       modelSlip;
    dacSelect_t modelSel;
    sample_t    prevStrobeSample;
    sample_t    expHeld;
    sample_t    lastHeld;
    logic       lastEn;
    sample_t    sampleQ[$];
    strobes_t   strobeQ[$];
    sample_t    dacSampleQ[$];
    logic       dacEnQ[$];
    dacSelect_t dacSelQ[$];

    trellisFrontEnd #(
        .multihSpaceBase(spaceBase)
    ) trellisFrontEnd_inst (
        .clk          (clk),
        .symbolSlipped(symbolSlipped),
        .sampleIn     (sampleIn),
        .strobesIn    (strobesIn),
        .cs           (cs),
        .wr0          (wr0),
        .addr         (addr),
        .din          (din),
        .dout         (dout),
        .dacData      (dacData),
        .dacClkEn     (dacClkEn),
        .sampleOut    (sampleOut),
        .strobesOut   (strobesOut)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
            $display("timeout: run did not finish within %0d cycles", timeoutLimit);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic signed [sampleWidth-1:0] dacValue(input dacSource_t src,
                                                               input sample_t s);
        case (src)
            dacTrellisI: return s.i;
            dacTrellisQ: return s.q;
            default: return '0;
        endcase
    endfunction

    task automatic addStep(input stepKind_t kind, input logic [addrWidth-1:0] a,
                           input logic [dataWidth-1:0] d, input int cycles);
        step_t s;
        s.kind = kind;
        s.addr = a;
        s.data = d;
        s.cycles = cycles;
        stepTable.push_back(s);
    endtask

    // register writes as the bus rules define them
    task automatic writeRegs(input logic [addrWidth-1:0] a, input logic [dataWidth-1:0] d);
        if (a[addrWidth-1:spaceDecodeLsb] == spaceBase[addrWidth-1:spaceDecodeLsb]) begin
            if (a[regAddrWidth-1:0] == regControl) begin
                modelDelay = d[ctrlDelayBit];
                modelSlip = d[ctrlSlipBit];
                if (d[ctrlSlipBit]) slipsAsked++;
            end else if (a[regAddrWidth-1:0] == regDacSelect) begin
                for (int n = 0; n < dacChannels; n++) begin
                    modelSel[n] = dacSource_t'(d[n*dacSelWidth +: dacSelWidth]);
                end
            end
        end
    endtask

    task automatic updateModel(input stepKind_t kind, input logic [addrWidth-1:0] a,
                               input logic [dataWidth-1:0] d, input strobes_t st,
                               input sample_t s);
        strobes_t expSt;
        if (kind == stepWrite) writeRegs(a, d);
        expSt = st;
        if (st.symEn) symEnIn++;
        // pending slip eats the next symEn
        if (modelSlip && st.symEn) begin
            expSt.symEn = 1'b0;
            modelSlip = 1'b0;
        end
        if (st.sym2xEn) begin
            expHeld = modelDelay ? prevStrobeSample : s;
            prevStrobeSample = s;
        end
        sampleQ.push_back(expHeld);
        strobeQ.push_back(expSt);
        // DAC entry belongs to last cycle's input, with the select now in force
        dacSampleQ.push_back(lastHeld);
        dacEnQ.push_back(lastEn);
        dacSelQ.push_back(modelSel);
        lastHeld = expHeld;
        lastEn = expSt.sym2xEn;
    endtask

    task automatic checkOutputs();
        sample_t    wantSample;
        strobes_t   wantStrobes;
        sample_t    held;
        logic       en;
        dacSelect_t sel;
        if (strobeQ.size() >= 2) begin
            wantSample = sampleQ.pop_front();
            wantStrobes = strobeQ.pop_front();
            compareStrobes("strobesOut", strobesOut, wantStrobes);
            if (wantStrobes.sym2xEn) compareSample("sampleOut", sampleOut, wantSample);
            if (strobesOut.symEn) symEnOut++;
        end
        if (dacSelQ.size() >= 2) begin
            held = dacSampleQ.pop_front();
            en = dacEnQ.pop_front();
            sel = dacSelQ.pop_front();
            for (int ch = 0; ch < dacChannels; ch++) begin
                compareDac(ch, dacData[ch], dacClkEn[ch], dacValue(sel[ch], held),
                           en && (sel[ch] == dacTrellisI || sel[ch] == dacTrellisQ));
            end
        end
    endtask

    // one clock of stimulus, checks of the previous outputs first
    task automatic applyCycle(input stepKind_t kind, input logic [addrWidth-1:0] a,
                              input logic [dataWidth-1:0] d);
        strobes_t st;
        int       strobeIndex;
        @(negedge clk);
        checkOutputs();
        st = '0;
        sampleIn = '0;
        cs = (kind == stepRead || kind == stepWrite);
        wr0 = (kind == stepWrite);
        addr = a;
        din = (kind == stepWrite) ? d : '0;
        if (kind == stepRun) begin
            rngState = xorshift32(rngState);
            sampleIn.i = rngState[sampleWidth-1:0];
            rngState = xorshift32(rngState);
            sampleIn.q = rngState[sampleWidth-1:0];
            strobeIndex = runCycle / 2;
            st.sym2xEn = (runCycle % 2 == 0);
            st.symEn = st.sym2xEn && (strobeIndex % 2 == 1);
            st.symEnEven = st.sym2xEn && (strobeIndex % 4 == 3);
            runCycle++;
        end
        strobesIn = st;
        updateModel(kind, a, d, st, sampleIn);
        if (kind == stepRead) begin
            #10;
            compareWord("dout", dout, d);
        end
    endtask

    initial begin
        int tableCycles;
        symbolSlipped = 1'b1;
        sampleIn = '0;
        strobesIn = '0;
        cs = 1'b0;
        wr0 = 1'b0;
        addr = '0;
        din = '0;
        modelDelay = 1'b0;
        modelSlip = 1'b0;
        prevStrobeSample = '0;
        expHeld = '0;
        lastHeld = '0;
        lastEn = 1'b0;
        for (int n = 0; n < dacChannels; n++) begin
            modelSel[n] = dacOff;
        end

        // ----------------------------------------------------------
        // step table
        // ----------------------------------------------------------
        addStep(stepRead, ctrlAddr, 32'h0, 1);
        addStep(stepRead, dacAddr, 32'h0, 1);
        addStep(stepRun, '0, '0, 40);
        addStep(stepWrite, dacAddr, 32'h09, 1);
        addStep(stepRead, dacAddr, 32'h09, 1);
        addStep(stepRun, '0, '0, 40);
        addStep(stepWrite, ctrlAddr, 32'h2, 1);
        addStep(stepRead, ctrlAddr, 32'h2, 1);
        addStep(stepRun, '0, '0, 40);
        addStep(stepWrite, dacAddr, 32'h12, 1);
        addStep(stepRun, '0, '0, 24);
        // slip with the half-symbol delay on, then with it off
        addStep(stepWrite, ctrlAddr, 32'h3, 1);
        addStep(stepRead, ctrlAddr, 32'h3, 1);
        addStep(stepRun, '0, '0, 40);
        addStep(stepRead, ctrlAddr, 32'h2, 1);
        addStep(stepWrite, ctrlAddr, 32'h1, 1);
        addStep(stepRun, '0, '0, 32);
        addStep(stepRead, ctrlAddr, 32'h0, 1);
        // outside the space
        addStep(stepWrite, outsideAddr, 32'h3, 1);
        addStep(stepWrite, outsideAddr + 13'h1, 32'h3F, 1);
        addStep(stepRead, outsideAddr, 32'h0, 1);
        addStep(stepRead, ctrlAddr, 32'h0, 1);
        addStep(stepRead, dacAddr, 32'h12, 1);
        addStep(stepRun, '0, '0, 32);
        addStep(stepWrite, dacAddr, 32'h26, 1);
        addStep(stepRun, '0, '0, 24);
        addStep(stepIdle, '0, '0, 4);

        tableCycles = 0;
        foreach (stepTable[k]) tableCycles += stepTable[k].cycles;
        timeoutLimit = tableCycles + 50;

        repeat (5) @(posedge clk);
        @(negedge clk);
        symbolSlipped = 1'b0;
        compareStrobes("strobesOut", strobesOut, '0);
        for (int ch = 0; ch < dacChannels; ch++) begin
            compareDac(ch, dacData[ch], dacClkEn[ch], '0, 1'b0);
        end

        foreach (stepTable[k]) begin
            repeat (stepTable[k].cycles) begin
                applyCycle(stepTable[k].kind, stepTable[k].addr, stepTable[k].data);
            end
        end

        if (symEnOut != symEnIn - slipsAsked) begin
            otherErrors++;
            $display("symEn pulse count is off: %0d in, %0d out, %0d slips requested",
                     symEnIn, symEnOut, slipsAsked);
        end
        $display("errors: sample %0d, strobes %0d, dout %0d, dac %0d, other %0d",
                 sampleErrors, strobeErrors, wordErrors, dacErrors, otherErrors);
        if (sampleErrors + strobeErrors + wordErrors + dacErrors + otherErrors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+.
trellisPkg.sv
trellisRegDecode.sv
symbolSlipper.sv
sampleAligner.sv
dacOutputMux.sv
trellisFrontEnd.sv
tbTrellisFrontEnd.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the trellis front end testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

logFile=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    -f list.f --top-module tbTrellisFrontEnd -o simTrellisFrontEnd

./obj_dir/simTrellisFrontEnd | tee "$logFile"

if grep -qF "** FAIL **" "$logFile"; then
    echo "simulation failed, see $logFile"
    exit 1
fi
echo "simulation passed"
